// ==== common/issue_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface issue_if;
    import mips_pkg::*;

    logic   valid;
    logic   alu_ready;
    logic   mem_ready;
    issue_t data;

    // fork to both units, taken only when both are ready
    modport decoder (
        output valid,
        output data,
        input  alu_ready,
        input  mem_ready
    );

    modport alu (
        input  valid,
        input  data,
        output alu_ready,
        input  mem_ready
    );

    modport mem (
        input  valid,
        input  data,
        input  alu_ready,
        output mem_ready
    );

endinterface

`default_nettype wire

// ==== common/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int NUM_REGS   = 32;
    localparam int DMEM_WORDS = 64;
    // word index bits of a byte address
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // opcode field, instr[31:26]
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2B;

    // function field of R-type, instr[5:0]
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_MULT = 6'h18;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2A;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_mul,
        op_and,
        op_or,
        op_slt,
        op_addi,
        op_lw,
        op_sw,
        op_nop
    } op_e;

    // dest is 0 for sw and nop
    typedef struct packed {
        op_e      op;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
        reg_idx_t dest;
    } issue_t;

    typedef struct packed {
        op_e      op;
        reg_idx_t dest;
        word_t    value;
    } alu_res_t;

    // loaded word for lw, rt value otherwise
    typedef struct packed {
        word_t value;
    } mem_res_t;

endpackage

`default_nettype wire

// ==== decode/instr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     instr_valid,
    output logic                    instr_ready,
    input  wire mips_pkg::word_t    instr,
    input  wire                     wb_en,
    input  wire mips_pkg::reg_idx_t wb_dest,
    input  wire mips_pkg::word_t    wb_data,
    issue_if.decoder                issue
);
    import mips_pkg::*;

    logic [5:0]          opcode;
    logic [5:0]          funct;
    reg_idx_t            rs_idx;
    reg_idx_t            rt_idx;
    reg_idx_t            rd_idx;
    op_e                 dec_op;
    reg_idx_t            dec_dest;
    word_t               imm_ext;
    word_t               rs_val;
    word_t               rt_val;
    logic [NUM_REGS-1:0] busy;
    logic                hazard;
    logic                issue_fire;
    logic                accept;

    assign opcode  = instr[31:26];
    assign rs_idx  = instr[25:21];
    assign rt_idx  = instr[20:16];
    assign rd_idx  = instr[15:11];
    assign funct   = instr[5:0];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        dec_op = op_nop;
        case (opcode)
            OPC_RTYPE: begin
                case (funct)
                    FN_ADD:  dec_op = op_add;
                    FN_SUB:  dec_op = op_sub;
                    FN_MULT: dec_op = op_mul;
                    FN_AND:  dec_op = op_and;
                    FN_OR:   dec_op = op_or;
                    FN_SLT:  dec_op = op_slt;
                    default: dec_op = op_nop;
                endcase
            end
            OPC_ADDI: dec_op = op_addi;
            OPC_LW:   dec_op = op_lw;
            OPC_SW:   dec_op = op_sw;
            default:  dec_op = op_nop;
        endcase
    end

    // I-type writes rt, R-type writes rd
    always_comb begin
        case (dec_op)
            op_addi, op_lw: dec_dest = rt_idx;
            op_sw, op_nop:  dec_dest = '0;
            default:        dec_dest = rd_idx;
        endcase
    end

    reg_file u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rs_idx),
        .rd_addr_b (rt_idx),
        .wr_en     (wb_en),
        .wr_addr   (wb_dest),
        .wr_data   (wb_data),
        .rd_data_a (rs_val),
        .rd_data_b (rt_val)
    );

    // busy[0] is never set
    assign hazard     = busy[rs_idx] | busy[rt_idx] | busy[dec_dest];
    assign issue_fire = issue.valid & issue.alu_ready & issue.mem_ready;
    assign instr_ready = !(issue.valid && !issue_fire) && !hazard;
    assign accept     = instr_valid & instr_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (wb_en) begin
                busy[wb_dest] <= 1'b0;
            end
            // a pending dest blocks acceptance, so no clash with the clear above
            if (accept && dec_dest != '0) begin
                busy[dec_dest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
        end else if (accept) begin
            issue.valid <= 1'b1;
        end else if (issue_fire) begin
            issue.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue.data <= '{op: dec_op, rs_val: rs_val, rt_val: rt_val,
                            imm: imm_ext, dest: dec_dest};
        end
    end

endmodule

`default_nettype wire

// ==== decode/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire mips_pkg::reg_idx_t rd_addr_a,
    input  wire mips_pkg::reg_idx_t rd_addr_b,
    input  wire                     wr_en,
    input  wire mips_pkg::reg_idx_t wr_addr,
    input  wire mips_pkg::word_t    wr_data,
    output mips_pkg::word_t         rd_data_a,
    output mips_pkg::word_t         rd_data_b
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // $zero reads as zero whatever is stored
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== flist.f ====
common/mips_pkg.sv
common/issue_if.sv
decode/reg_file.sv
decode/instr_decode.sv
src/alu_unit.sv
src/data_mem_unit.sv
src/retire_merge.sv
src/mips_exec_top.sv
testbench/tb_mips_exec.sv

// ==== src/alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
    input  wire                clk,
    input  wire                rst_n,
    issue_if.alu               issue,
    output logic               alu_valid,
    input  wire                alu_ready,
    output mips_pkg::alu_res_t alu_res
);
    import mips_pkg::*;

    word_t rs_val;
    word_t rt_val;
    word_t result;
    logic  take;

    assign rs_val = issue.data.rs_val;
    assign rt_val = issue.data.rt_val;

    // one entry: free when empty or draining this cycle
    assign issue.alu_ready = !alu_valid || alu_ready;
    assign take = issue.valid & issue.alu_ready & issue.mem_ready;

    always_comb begin
        case (issue.data.op)
            op_add:  result = rs_val + rt_val;
            op_sub:  result = rs_val - rt_val;
            op_mul:  result = rs_val * rt_val;
            op_and:  result = rs_val & rt_val;
            op_or:   result = rs_val | rt_val;
            op_slt:  result = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
            op_addi: result = rs_val + issue.data.imm;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else if (take) begin
            alu_valid <= 1'b1;
        end else if (alu_ready) begin
            alu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            alu_res <= '{op: issue.data.op, dest: issue.data.dest, value: result};
        end
    end

endmodule

`default_nettype wire

// ==== src/data_mem_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_mem_unit (
    input  wire                clk,
    input  wire                rst_n,
    issue_if.mem               issue,
    output logic               mem_valid,
    input  wire                mem_ready,
    output mips_pkg::mem_res_t mem_res
);
    import mips_pkg::*;

    word_t              dmem [DMEM_WORDS];
    word_t              mem_addr;
    logic [DMEM_AW-1:0] word_idx;
    logic               take;

    // byte address, wraps modulo the memory size
    assign mem_addr = issue.data.rs_val + issue.data.imm;
    assign word_idx = mem_addr[DMEM_AW+1:2];

    assign issue.mem_ready = !mem_valid || mem_ready;
    assign take = issue.valid & issue.alu_ready & issue.mem_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else if (take) begin
            mem_valid <= 1'b1;
        end else if (mem_ready) begin
            mem_valid <= 1'b0;
        end
    end

    // store lands on acceptance, so a later load sees it
    always_ff @(posedge clk) begin
        if (take && issue.data.op == op_sw) begin
            dmem[word_idx] <= issue.data.rt_val;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (issue.data.op == op_lw) begin
                mem_res.value <= dmem[word_idx];
            end else begin
                mem_res.value <= issue.data.rt_val;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mips_exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_exec_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       instr_valid,
    output logic                      instr_ready,
    input  wire mips_pkg::word_t      instr,
    output logic                      retire_valid,
    input  wire                       retire_ready,
    output mips_pkg::reg_idx_t        retire_dest,
    output mips_pkg::word_t           retire_data,
    output logic                      retire_wr_en
);
    import mips_pkg::*;

    logic     alu_valid;
    logic     alu_ready;
    alu_res_t alu_res;
    logic     mem_valid;
    logic     mem_ready;
    mem_res_t mem_res;
    logic     wb_en;
    reg_idx_t wb_dest;
    word_t    wb_data;

    issue_if issue_bus ();

    instr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .wb_en       (wb_en),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .issue       (issue_bus.decoder)
    );

    alu_unit u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue_bus.alu),
        .alu_valid (alu_valid),
        .alu_ready (alu_ready),
        .alu_res   (alu_res)
    );

    data_mem_unit u_dmem (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue_bus.mem),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_res   (mem_res)
    );

    retire_merge u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu_valid    (alu_valid),
        .alu_ready    (alu_ready),
        .alu_res      (alu_res),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_res      (mem_res),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_dest  (retire_dest),
        .retire_data  (retire_data),
        .retire_wr_en (retire_wr_en),
        .wb_en        (wb_en),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data)
    );

endmodule

`default_nettype wire

// ==== src/retire_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_merge (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         alu_valid,
    output logic                        alu_ready,
    input  wire mips_pkg::alu_res_t     alu_res,
    input  wire                         mem_valid,
    output logic                        mem_ready,
    input  wire mips_pkg::mem_res_t     mem_res,
    output logic                        retire_valid,
    input  wire                         retire_ready,
    output mips_pkg::reg_idx_t          retire_dest,
    output mips_pkg::word_t             retire_data,
    output logic                        retire_wr_en,
    output logic                        wb_en,
    output mips_pkg::reg_idx_t          wb_dest,
    output mips_pkg::word_t             wb_data
);
    import mips_pkg::*;

    logic  slot_free;
    logic  take;
    word_t sel_value;

    // join: each side is taken only together with the other
    assign slot_free = !retire_valid || retire_ready;
    assign alu_ready = slot_free && mem_valid;
    assign mem_ready = slot_free && alu_valid;
    assign take      = alu_valid && alu_ready;

    assign sel_value = (alu_res.op == op_lw || alu_res.op == op_sw) ? mem_res.value
                                                                      : alu_res.value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else if (take) begin
            retire_valid <= 1'b1;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            retire_dest  <= alu_res.dest;
            retire_data  <= sel_value;
            retire_wr_en <= (alu_res.dest != '0);
        end
    end

    // write-back pulse on the retire handshake
    assign wb_en   = retire_valid && retire_ready && retire_wr_en;
    assign wb_dest = retire_dest;
    assign wb_data = retire_data;

endmodule

`default_nettype wire

// ==== testbench/tb_mips_exec.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mips_exec;
    import mips_pkg::*;

    typedef struct packed {
        reg_idx_t dest;
        word_t    data;
        logic     wr_en;
    } expect_t;

    // arith 28, mem 16, chain 12, stall 24, zero reg 6
    localparam int TOTAL_INSTR = 86;
    localparam int CLK_PERIOD  = 100;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    logic     instr_ready;
    word_t    instr;
    logic     retire_valid;
    logic     retire_ready;
    reg_idx_t retire_dest;
    word_t    retire_data;
    logic     retire_wr_en;

    integer  seed;
    logic    stall_en;
    word_t   model_regs [NUM_REGS];
    word_t   model_mem [DMEM_WORDS];
    expect_t exp_q [$];
    string   name_q [$];
    logic [15:0] addr_list [8];
    int      prev;

    mips_exec_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_dest  (retire_dest),
        .retire_data  (retire_data),
        .retire_wr_en (retire_wr_en)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic word_t r_type(input logic [5:0] fn, input int rs, input int rt,
                                     input int rd);
        return {OPC_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] opc, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [5:0] pick_fn();
        case (rand_range(0, 5))
            0:       return FN_ADD;
            1:       return FN_SUB;
            2:       return FN_MULT;
            3:       return FN_AND;
            4:       return FN_OR;
            default: return FN_SLT;
        endcase
    endfunction

    // architectural model, applied in program order
    function automatic expect_t predict_retire(input word_t w);
        expect_t e;
        word_t   a;
        word_t   b;
        word_t   imm;
        word_t   addr;
        a    = (w[25:21] == 0) ? '0 : model_regs[w[25:21]];
        b    = (w[20:16] == 0) ? '0 : model_regs[w[20:16]];
        imm  = {{16{w[15]}}, w[15:0]};
        addr = a + imm;
        e    = '{dest: '0, data: '0, wr_en: 1'b0};
        if (w[31:26] == OPC_RTYPE) begin
            e.dest = w[15:11];
            case (w[5:0])
                FN_ADD:  e.data = a + b;
                FN_SUB:  e.data = a - b;
                FN_MULT: e.data = a * b;
                FN_AND:  e.data = a & b;
                FN_OR:   e.data = a | b;
                FN_SLT:  e.data = {31'd0, $signed(a) < $signed(b)};
                default: e.dest = '0;
            endcase
        end else if (w[31:26] == OPC_ADDI) begin
            e.dest = w[20:16];
            e.data = a + imm;
        end else if (w[31:26] == OPC_LW) begin
            e.dest = w[20:16];
            e.data = model_mem[addr[7:2]];
        end else if (w[31:26] == OPC_SW) begin
            e.data = b;
            model_mem[addr[7:2]] = b;
        end
        e.wr_en = (e.dest != 0);
        if (e.wr_en) begin
            model_regs[e.dest] = e.data;
        end
        return e;
    endfunction

    // hold valid until ready is seen, then log the expected retire
    task automatic send_instr(input word_t w, input string name);
        expect_t e;
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = w;
        #10;
        while (!instr_ready) begin
            @(negedge clk);
            #10;
        end
        e = predict_retire(w);
        exp_q.push_back(e);
        name_q.push_back(name);
        @(posedge clk);
    endtask

    task automatic drain();
        @(negedge clk);
        instr_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // compare one retire record per handshake
    always begin
        expect_t e;
        string   name;
        @(negedge clk);
        #10;
        if (retire_valid === 1'b1 && retire_ready === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run("an instruction retired although none was outstanding");
            end
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            check_reg_idx({name, " dest"}, e.dest, retire_dest);
            check_word({name, " data"}, e.data, retire_data);
            check_bit({name, " wr_en"}, e.wr_en, retire_wr_en);
        end
    end

    // random stall runs on the retire side
    always begin
        int len;
        @(negedge clk);
        if (stall_en && ($random(seed) & 3) == 0) begin
            len = 1 + ($random(seed) & 7);
            retire_ready = 1'b0;
            repeat (len) @(negedge clk);
            retire_ready = 1'b1;
        end
    end

    initial begin
        #(TOTAL_INSTR * 20 * CLK_PERIOD + 10 * CLK_PERIOD);
        fail_run("timeout: instructions did not retire in time");
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        retire_ready = 1'b1;
        stall_en     = 1'b0;
        seed         = 85;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("reset retire_valid", 1'b0, retire_valid);
        check_bit("reset instr_ready", 1'b1, instr_ready);

        for (int r = 1; r <= 8; r++) begin
            send_instr(i_type(OPC_ADDI, 0, r, 16'($random(seed))), "arith load");
        end
        for (int i = 0; i < 20; i++) begin
            send_instr(r_type(pick_fn(), rand_range(1, 8), rand_range(1, 8),
                              rand_range(1, 15)), "arith rtype");
        end
        drain();

        for (int i = 0; i < 8; i++) begin
            addr_list[i] = 16'($random(seed)) & 16'h00FC;
            send_instr(i_type(OPC_SW, 0, rand_range(1, 15), addr_list[i]), "mem store");
        end
        for (int i = 0; i < 8; i++) begin
            send_instr(i_type(OPC_LW, 0, 16 + i, addr_list[i]), "mem load");
        end
        drain();

        prev = 1;
        for (int i = 0; i < 12; i++) begin
            send_instr(r_type(pick_fn(), prev, rand_range(1, 8), 1 + (i % 5)), "chain");
            prev = 1 + (i % 5);
        end
        drain();

        stall_en = 1'b1;
        for (int i = 0; i < 24; i++) begin
            if (rand_range(0, 3) == 0) begin
                send_instr(i_type(OPC_ADDI, rand_range(0, 15), rand_range(1, 15),
                                  16'($random(seed))), "stall addi");
            end else begin
                send_instr(r_type(pick_fn(), rand_range(1, 15), rand_range(1, 15),
                                  rand_range(1, 15)), "stall rtype");
            end
        end
        drain();
        stall_en = 1'b0;

        send_instr(i_type(6'h3F, 1, 2, 16'h1234), "zero bad opcode");
        send_instr(r_type(6'h01, 1, 2, 3), "zero bad funct");
        send_instr(i_type(OPC_ADDI, 1, 0, 16'h0005), "zero addi r0");
        send_instr(r_type(FN_ADD, 1, 2, 0), "zero add r0");
        send_instr(r_type(FN_OR, 0, 0, 4), "zero read r0");
        send_instr(i_type(OPC_ADDI, 0, 5, 16'h0000), "zero addi from r0");
        drain();

        // a few idle cycles so a stray extra retire is still caught
        repeat (5) @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
